// File: rtl/core_pkg.sv
package core_pkg;

   parameter int XLEN = 32;

   // Major opcodes of the supported RV32I subset.
   typedef enum logic [6:0] {
      OP_LUI   = 7'b0110111,
      OP_AUIPC = 7'b0010111,
      OP_JAL   = 7'b1101111,
      OP_JALR  = 7'b1100111,
      OP_IMM   = 7'b0010011,
      OP_REG   = 7'b0110011
   } opcode_e;

   typedef enum logic [1:0] {
      ST_FETCH,   // Waiting for the instruction bus ack.
      ST_DECODE,  // One cycle on the latched word.
      ST_EXEC,    // 32 serial bit cycles.
      ST_HALT     // Misaligned jump seen.
   } seq_state_e;

endpackage

// File: rtl/core_if.sv
interface seq_if;

   logic                              pc_en;
   logic [$clog2(core_pkg::XLEN)-1:0] cnt;
   logic                              cnt2;
   logic                              cnt12to31;
   logic                              cnt_done;

   modport seq (
      output pc_en,
      output cnt,
      output cnt2,
      output cnt12to31,
      output cnt_done
   );

   modport user (
      input pc_en,
      input cnt,
      input cnt2,
      input cnt12to31,
      input cnt_done
   );

endinterface

interface ctrl_if;

   logic       jump;
   logic       jal_or_jalr;
   logic       utype;
   logic       pc_rel;
   logic       imm;        // Serial immediate, LSB first.
   logic       use_imm;
   logic       rd_en;
   logic [4:0] rd_addr;
   logic [4:0] rs1_addr;
   logic [4:0] rs2_addr;

   modport dec (
      output jump, jal_or_jalr, utype, pc_rel, imm, use_imm,
      output rd_en, rd_addr, rs1_addr, rs2_addr
   );

   modport exe (
      input jump, jal_or_jalr, utype, pc_rel, imm, use_imm,
      input rd_en, rd_addr, rs1_addr, rs2_addr
   );

endinterface

// File: rtl/core_sequencer.sv
module core_sequencer (
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_ibus_ack,
   input  logic i_bad_pc,
   input  logic i_jump,
   output logic o_fault,
   seq_if.seq   seq
);

   localparam int CNT_W = $clog2(core_pkg::XLEN);

   core_pkg::seq_state_e state;
   logic [CNT_W-1:0]     cnt;
   logic                 pc_en_r;
   logic                 last_bit;

   assign last_bit = (cnt == '1);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state   <= core_pkg::ST_FETCH;
         cnt     <= '0;
         pc_en_r <= 1'b0;
         o_fault <= 1'b0;
      end else begin
         case (state)
            core_pkg::ST_FETCH: begin
               if (i_ibus_ack) begin
                  state <= core_pkg::ST_DECODE;
               end
            end
            core_pkg::ST_DECODE: begin
               state   <= core_pkg::ST_EXEC;
               pc_en_r <= 1'b1;
            end
            core_pkg::ST_EXEC: begin
               cnt <= cnt + 1'b1;                        // Wraps to 0 after bit 31.
               if (cnt == CNT_W'(1) && i_jump && i_bad_pc) begin
                  o_fault <= 1'b1;                       // Target bit 1 set.
               end
               if (last_bit) begin
                  pc_en_r <= 1'b0;
                  state   <= o_fault ? core_pkg::ST_HALT : core_pkg::ST_FETCH;
               end
            end
            default: begin
               state <= core_pkg::ST_HALT;               // Held until reset.
            end
         endcase
      end
   end

   assign seq.pc_en     = pc_en_r;
   assign seq.cnt       = cnt;
   assign seq.cnt2      = pc_en_r & (cnt == CNT_W'(2));
   assign seq.cnt12to31 = pc_en_r & (cnt >= CNT_W'(12));
   assign seq.cnt_done  = pc_en_r & last_bit;

   a_pc_en_exec: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      seq.pc_en |-> (state == core_pkg::ST_EXEC)
   );

   // Fault is sticky until the next reset.
   a_fault_sticky: assert property (
      @(posedge clk) $fell(o_fault) |-> !$past(i_rst_n)
   );

endmodule

// File: rtl/instr_decode.sv
module instr_decode (
   input  logic                      clk,
   input  logic                      i_rst_n,
   input  logic                      i_ibus_ack,
   input  logic [core_pkg::XLEN-1:0] i_ibus_rdt,
   seq_if.user                       seq,
   ctrl_if.dec                       ctrl
);

   localparam int XLEN = core_pkg::XLEN;

   logic [XLEN-1:0]    instr_r;
   logic [XLEN-1:0]    imm_r;
   logic [XLEN-1:0]    imm_next;
   core_pkg::opcode_e  opcode;
   logic [2:0]         funct3;
   logic [6:0]         funct7;
   logic               is_lui;
   logic               is_auipc;
   logic               is_jal;
   logic               is_jalr;
   logic               is_addi;
   logic               is_add;

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         instr_r <= i_ibus_rdt;
      end
   end

   // Immediate by format of the incoming word.
   always_comb begin
      case (core_pkg::opcode_e'(i_ibus_rdt[6:0]))
         core_pkg::OP_LUI, core_pkg::OP_AUIPC: begin
            imm_next = {i_ibus_rdt[31:12], 12'b0};
         end
         core_pkg::OP_JAL: begin
            imm_next = {{12{i_ibus_rdt[31]}}, i_ibus_rdt[19:12], i_ibus_rdt[20],
                        i_ibus_rdt[30:21], 1'b0};
         end
         default: begin
            imm_next = {{20{i_ibus_rdt[31]}}, i_ibus_rdt[31:20]};
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         imm_r <= imm_next;
      end else if (seq.pc_en) begin
         imm_r <= {imm_r[XLEN-1], imm_r[XLEN-1:1]};     // Top bit held as sign.
      end
   end

   assign opcode = core_pkg::opcode_e'(instr_r[6:0]);
   assign funct3 = instr_r[14:12];
   assign funct7 = instr_r[31:25];

   always_comb begin
      is_lui   = 1'b0;
      is_auipc = 1'b0;
      is_jal   = 1'b0;
      is_jalr  = 1'b0;
      is_addi  = 1'b0;
      is_add   = 1'b0;
      case (opcode)
         core_pkg::OP_LUI:   is_lui   = 1'b1;
         core_pkg::OP_AUIPC: is_auipc = 1'b1;
         core_pkg::OP_JAL:   is_jal   = 1'b1;
         core_pkg::OP_JALR:  is_jalr  = (funct3 == 3'b000);
         core_pkg::OP_IMM:   is_addi  = (funct3 == 3'b000);
         core_pkg::OP_REG:   is_add   = (funct3 == 3'b000) && (funct7 == 7'b0);
         default: ;                                      // Anything else is a no-op.
      endcase
   end

   assign ctrl.jump        = is_jal | is_jalr;
   assign ctrl.jal_or_jalr = is_jal | is_jalr;
   assign ctrl.utype       = is_lui | is_auipc;
   assign ctrl.pc_rel      = !(is_lui | is_jalr);
   assign ctrl.imm         = imm_r[0];
   assign ctrl.use_imm     = !is_add;
   assign ctrl.rd_addr     = instr_r[11:7];
   assign ctrl.rs1_addr    = instr_r[19:15];
   assign ctrl.rs2_addr    = instr_r[24:20];
   assign ctrl.rd_en       = (is_lui | is_auipc | is_jal | is_jalr | is_addi | is_add) &&
                             (instr_r[11:7] != 5'd0);

   // No new word is loaded while the immediate is shifting out.
   a_imm_shift: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      seq.pc_en |-> !i_ibus_ack
   );

endmodule

// File: rtl/pc_ctrl.sv
module pc_ctrl #(
   parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
   input  logic                      clk,
   input  logic                      i_rst_n,
   seq_if.user                       seq,
   ctrl_if.exe                       ctrl,
   input  logic                      i_buf,
   input  logic                      i_ibus_ack,
   input  logic                      i_fault,
   output logic                      o_rd,
   output logic                      o_bad_pc,
   output logic [core_pkg::XLEN-1:0] o_ibus_adr,
   output logic                      o_ibus_cyc_en
);

   logic pc;
   logic new_pc;
   logic pc_plus_4;
   logic pc_plus_4_cy;
   logic pc_plus_4_cy_r;
   logic pc_plus_off;
   logic pc_plus_off_cy;
   logic pc_plus_off_cy_r;
   logic pc_plus_off_al;
   logic off_a;
   logic off_b;
   logic pc_en_q;
   logic rst_q;
   logic en_r;

   assign pc = o_ibus_adr[0];                            // Current PC bit.

   assign {pc_plus_4_cy, pc_plus_4} = pc + seq.cnt2 + pc_plus_4_cy_r;

   // Offset from the U or J immediate, or the ALU sum for JALR.
   assign off_a = ctrl.pc_rel & pc;
   assign off_b = ctrl.utype  ? (ctrl.imm & seq.cnt12to31) :
                  ctrl.pc_rel ? ctrl.imm : i_buf;
   assign {pc_plus_off_cy, pc_plus_off} = off_a + off_b + pc_plus_off_cy_r;

   assign pc_plus_off_al = pc_plus_off & pc_en_q;        // Bit 0 forced low.

   assign new_pc   = ctrl.jump ? pc_plus_off_al : pc_plus_4;
   assign o_rd     = (ctrl.utype & pc_plus_off_al) | (ctrl.jal_or_jalr & pc_plus_4);
   assign o_bad_pc = pc_plus_off_al;

   assign o_ibus_cyc_en = en_r;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc_plus_4_cy_r   <= 1'b0;
         pc_plus_off_cy_r <= 1'b0;
         pc_en_q          <= 1'b0;
         o_ibus_adr       <= RESET_PC;
      end else begin
         pc_plus_4_cy_r   <= seq.pc_en & pc_plus_4_cy;
         pc_plus_off_cy_r <= seq.pc_en & pc_plus_off_cy;
         pc_en_q          <= seq.pc_en;
         if (seq.pc_en) begin
            o_ibus_adr <= {new_pc, o_ibus_adr[core_pkg::XLEN-1:1]};
         end
      end
   end

   // Bus cycle enable, armed by reset release and by each finished execute.
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         rst_q <= 1'b1;
         en_r  <= 1'b0;
      end else begin
         rst_q <= 1'b0;
         if (rst_q || (seq.cnt_done && !i_fault)) begin
            en_r <= 1'b1;
         end else if (en_r && i_ibus_ack) begin
            en_r <= 1'b0;
         end
      end
   end

endmodule

// File: rtl/serial_alu.sv
module serial_alu (
   input  logic clk,
   input  logic i_rst_n,
   seq_if.user  seq,
   ctrl_if.exe  ctrl,
   input  logic i_rs1,
   input  logic i_rs2,
   input  logic i_pc_rd,
   output logic o_sum,
   output logic o_rd
);

   logic op_b;
   logic cy;
   logic cy_r;

   assign op_b = ctrl.use_imm ? ctrl.imm : i_rs2;
   assign {cy, o_sum} = i_rs1 + op_b + cy_r;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         cy_r <= 1'b0;
      end else begin
         cy_r <= seq.pc_en & cy;                         // Zero again by bit 0.
      end
   end

   // LUI takes the immediate, AUIPC and jumps take the PC result.
   always_comb begin
      if (ctrl.utype && !ctrl.pc_rel) begin
         o_rd = ctrl.imm;
      end else if (ctrl.utype || ctrl.jal_or_jalr) begin
         o_rd = i_pc_rd;
      end else begin
         o_rd = o_sum;
      end
   end

endmodule

// File: rtl/serial_regfile.sv
module serial_regfile (
   input  logic clk,
   seq_if.user  seq,
   ctrl_if.exe  ctrl,
   input  logic i_rd,
   output logic o_rs1,
   output logic o_rs2
);

   logic [core_pkg::XLEN-1:0] regs [32];
   logic                      wr_en;

   // x0 is never stored and reads as zero.
   assign o_rs1 = (ctrl.rs1_addr == 5'd0) ? 1'b0 : regs[ctrl.rs1_addr][seq.cnt];
   assign o_rs2 = (ctrl.rs2_addr == 5'd0) ? 1'b0 : regs[ctrl.rs2_addr][seq.cnt];

   assign wr_en = seq.pc_en && ctrl.rd_en && (ctrl.rd_addr != 5'd0);

   always_ff @(posedge clk) begin
      if (wr_en) begin
         regs[ctrl.rd_addr][seq.cnt] <= i_rd;            // One bit per cycle.
      end
   end

   // The decoder already keeps rd_en low for x0.
   a_no_x0_write: assert property (
      @(posedge clk) (seq.pc_en && ctrl.rd_en) |-> (ctrl.rd_addr != 5'd0)
   );

endmodule

// File: rtl/core_top.sv
module core_top #(
   parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
   input  logic                      clk,
   input  logic                      i_rst_n,
   input  logic [core_pkg::XLEN-1:0] i_ibus_rdt,
   input  logic                      i_ibus_ack,
   output logic [core_pkg::XLEN-1:0] o_ibus_adr,
   output logic                      o_ibus_cyc,
   output logic                      o_fault
);

   seq_if  seq ();
   ctrl_if ctrl ();

   logic rs1_bit;
   logic rs2_bit;
   logic sum_bit;
   logic alu_rd;
   logic pc_rd;
   logic bad_pc;

   core_sequencer u_seq (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_bad_pc   (bad_pc),
      .i_jump     (ctrl.jump),
      .o_fault    (o_fault),
      .seq        (seq)
   );

   instr_decode u_dec (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .seq        (seq),
      .ctrl       (ctrl)
   );

   pc_ctrl #(
      .RESET_PC (RESET_PC)
   ) u_pc (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .seq           (seq),
      .ctrl          (ctrl),
      .i_buf         (sum_bit),
      .i_ibus_ack    (i_ibus_ack),
      .i_fault       (o_fault),
      .o_rd          (pc_rd),
      .o_bad_pc      (bad_pc),
      .o_ibus_adr    (o_ibus_adr),
      .o_ibus_cyc_en (o_ibus_cyc)
   );

   serial_alu u_alu (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .seq     (seq),
      .ctrl    (ctrl),
      .i_rs1   (rs1_bit),
      .i_rs2   (rs2_bit),
      .i_pc_rd (pc_rd),
      .o_sum   (sum_bit),
      .o_rd    (alu_rd)
   );

   serial_regfile u_rf (
      .clk   (clk),
      .seq   (seq),
      .ctrl  (ctrl),
      .i_rd  (alu_rd),
      .o_rs1 (rs1_bit),
      .o_rs2 (rs2_bit)
   );

endmodule

// File: testbench/core_top_tb.sv
module core_top_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [31:0] RESET_PC = 32'h100;
   localparam int          N_STEPS  = 18;
   localparam int          WAIT_MAX = 200;
   localparam int          RST_WAIT = 1;      // First edge after release.
   localparam int          EXE_WAIT = 33;     // Decode plus 32 serial bits.

   localparam logic [6:0] OPC_LUI   = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC = 7'b0010111;
   localparam logic [6:0] OPC_JALR  = 7'b1100111;
   localparam logic [6:0] OPC_IMM   = 7'b0010011;
   localparam logic [31:0] NOP_SW   = 32'h0000_2023;  // Unsupported store executes as a no-op.

   logic        clk = 1'b0;
   logic        i_rst_n;
   logic [31:0] i_ibus_rdt;
   logic        i_ibus_ack;
   logic [31:0] o_ibus_adr;
   logic        o_ibus_cyc;
   logic        o_fault;

   logic [31:0] step_adr   [N_STEPS];
   logic [31:0] step_word  [N_STEPS];
   logic        step_fault [N_STEPS];
   int          n_loaded = 0;
   int          errors   = 0;
   int          timeouts = 0;
   logic        aborted  = 1'b0;
   logic [31:0] lcg_state = 32'd48996;

   core_top #(
      .RESET_PC (RESET_PC)
   ) UUT (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .o_fault    (o_fault)
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                         input logic [4:0] rd, input logic [6:0] opc);
      return {imm[11:0], rs1, 3'b000, rd, opc};
   endfunction

   function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
      return {imm, rd, opc};
   endfunction

   function automatic logic [31:0] enc_j(input logic [31:0] off, input logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
   endfunction

   function automatic logic [31:0] enc_add(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
      return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
   endfunction

   // Samples settle and inputs change 2 ns after the edge.
   task automatic tick();
      @(posedge clk);
      #2;
   endtask

   task automatic add_step(input logic [31:0] adr, input logic [31:0] word, input logic flt);
      step_adr[n_loaded]   = adr;
      step_word[n_loaded]  = word;
      step_fault[n_loaded] = flt;
      n_loaded++;
   endtask

   task automatic load_program();
      add_step(32'h100,  NOP_SW, 1'b0);
      add_step(32'h104,  enc_i(32'h123, 5'd0, 5'd2, OPC_IMM), 1'b0);   // x2 = 0x123
      add_step(32'h108,  enc_j(32'd16, 5'd0), 1'b0);
      add_step(32'h118,  enc_j(-32'sd8, 5'd0), 1'b0);
      add_step(32'h110,  enc_u(20'h00002, 5'd1, OPC_LUI), 1'b0);       // x1 = 0x2000
      add_step(32'h114,  enc_i(32'h0, 5'd1, 5'd0, OPC_JALR), 1'b0);
      add_step(32'h2000, enc_i(32'h41, 5'd1, 5'd0, OPC_JALR), 1'b0);   // Odd target.
      add_step(32'h2040, enc_add(5'd2, 5'd2, 5'd1), 1'b0);             // x2 = 0x2123
      add_step(32'h2044, enc_i(-32'sd35, 5'd2, 5'd2, OPC_IMM), 1'b0);  // x2 = 0x2100
      add_step(32'h2048, enc_i(32'h0, 5'd2, 5'd0, OPC_JALR), 1'b0);
      add_step(32'h2100, enc_i(32'h55, 5'd0, 5'd0, OPC_IMM), 1'b0);    // Discarded write.
      add_step(32'h2104, enc_i(32'h300, 5'd0, 5'd0, OPC_JALR), 1'b0);
      add_step(32'h300,  enc_j(32'h100, 5'd1), 1'b0);                  // x1 = 0x304
      add_step(32'h400,  NOP_SW, 1'b0);
      add_step(32'h404,  enc_i(32'h0, 5'd1, 5'd0, OPC_JALR), 1'b0);
      add_step(32'h304,  enc_u(20'h00001, 5'd3, OPC_AUIPC), 1'b0);     // x3 = 0x1304
      add_step(32'h308,  enc_i(32'h0, 5'd3, 5'd0, OPC_JALR), 1'b0);
      add_step(32'h1304, enc_i(32'h6, 5'd3, 5'd0, OPC_JALR), 1'b1);    // Target 0x130a.
   endtask

   task automatic apply_reset();
      i_rst_n    = 1'b0;
      i_ibus_ack = 1'b0;
      i_ibus_rdt = '0;
      repeat (10) tick();
      if (o_ibus_adr !== RESET_PC) begin
         $display("FAIL %0t: o_ibus_adr expected %h, got %h", $time, RESET_PC, o_ibus_adr);
         errors++;
      end
      if (o_ibus_cyc !== 1'b0 || o_fault !== 1'b0) begin
         $display("FAIL %0t: o_ibus_cyc/o_fault expected 0/0, got %b/%b",
                  $time, o_ibus_cyc, o_fault);
         errors++;
      end
      i_rst_n = 1'b1;
   endtask

   task automatic wait_fetch(input logic [31:0] exp_adr, input int exp_wait);
      int n;
      n = 0;
      while (o_ibus_cyc !== 1'b1 && n < WAIT_MAX) begin
         tick();
         n++;
      end
      if (o_ibus_cyc !== 1'b1) begin
         $display("Timeout at %0t: no fetch request for address %h", $time, exp_adr);
         timeouts++;
         aborted = 1'b1;
      end else begin
         if (n != exp_wait) begin
            $display("FAIL %0t: o_ibus_cyc latency expected %0d, got %0d",
                     $time, exp_wait, n);
            errors++;
         end
         if (o_ibus_adr !== exp_adr) begin
            $display("FAIL %0t: o_ibus_adr expected %h, got %h", $time, exp_adr, o_ibus_adr);
            errors++;
         end
         if (o_fault !== 1'b0) begin
            $display("FAIL %0t: o_fault expected 0, got %b", $time, o_fault);
            errors++;
         end
      end
   endtask

   task automatic ack_word(input logic [31:0] word);
      logic [31:0] held_adr;
      int          d;
      held_adr  = o_ibus_adr;
      lcg_state = lcg_next(lcg_state);
      d         = int'(lcg_state[17:16]);   // 0 to 3 wait cycles.
      for (int k = 0; k < d; k++) begin
         tick();
         if (o_ibus_adr !== held_adr) begin
            $display("FAIL %0t: o_ibus_adr expected %h, got %h", $time, held_adr, o_ibus_adr);
            errors++;
         end
         if (o_ibus_cyc !== 1'b1) begin
            $display("FAIL %0t: o_ibus_cyc expected 1, got %b", $time, o_ibus_cyc);
            errors++;
         end
      end
      i_ibus_ack = 1'b1;
      i_ibus_rdt = word;
      tick();
      i_ibus_ack = 1'b0;
      i_ibus_rdt = '0;
      if (o_ibus_cyc !== 1'b0) begin
         $display("FAIL %0t: o_ibus_cyc expected 0, got %b", $time, o_ibus_cyc);
         errors++;
      end
   endtask

   task automatic check_halt();
      int n;
      n = 0;
      while (o_fault !== 1'b1 && n < WAIT_MAX) begin
         tick();
         n++;
      end
      if (o_fault !== 1'b1) begin
         $display("Timeout at %0t: misaligned jump never raised o_fault", $time);
         timeouts++;
         aborted = 1'b1;
      end else begin
         n = 0;
         while (o_ibus_cyc === 1'b0 && o_fault === 1'b1 && n < 100) begin
            tick();
            n++;
         end
         if (n < 100) begin
            $display("FAIL %0t: o_ibus_cyc/o_fault expected 0/1, got %b/%b",
                     $time, o_ibus_cyc, o_fault);
            errors++;
         end
      end
   endtask

   initial begin
      i_rst_n    = 1'b0;
      i_ibus_ack = 1'b0;
      i_ibus_rdt = '0;
      load_program();
      apply_reset();
      for (int i = 0; i < n_loaded && !aborted; i++) begin
         wait_fetch(step_adr[i], (i == 0) ? RST_WAIT : EXE_WAIT);
         if (!aborted) begin
            ack_word(step_word[i]);
            if (step_fault[i]) begin
               check_halt();
            end
         end
      end
      // A fresh reset leaves the halt state and restarts at RESET_PC.
      if (!aborted) begin
         apply_reset();
         for (int i = 0; i < 2 && !aborted; i++) begin
            wait_fetch(step_adr[i], (i == 0) ? RST_WAIT : EXE_WAIT);
            if (!aborted) begin
               ack_word(step_word[i]);
            end
         end
         if (!aborted) begin
            wait_fetch(step_adr[2], EXE_WAIT);
         end
      end
      $display("Errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: core_top.f
rtl/core_pkg.sv
rtl/core_if.sv
rtl/core_sequencer.sv
rtl/instr_decode.sv
rtl/pc_ctrl.sv
rtl/serial_alu.sv
rtl/serial_regfile.sv
rtl/core_top.sv
testbench/core_top_tb.sv
